/* dv/gate_tests.txt */
# test <name> <every|random>, req <count> <request bytes>, exp <count> <response bytes>
# Bytes in hex, network order; mode says how often the host pulls tx_stb
test nonce_echo every
req 8
01 23 45 67 89 ab cd ef
exp 8
01 23 45 67 89 ab cd ef
test write_read every
req 24
a0 a1 a2 a3 a4 a5 a6 a7 00 00 00 05 ca fe f0 0d
10 00 00 05 00 00 00 00
exp 24
a0 a1 a2 a3 a4 a5 a6 a7 00 00 00 05 00 00 00 00
10 00 00 05 ca fe f0 0d
test four_txn every
req 40
5a 5b 5c 5d 5e 5f 60 61 00 00 00 01 11 22 33 44
00 00 00 02 55 66 77 88 10 00 00 01 00 00 00 00
00 00 00 01 99 aa bb cc
exp 40
5a 5b 5c 5d 5e 5f 60 61 00 00 00 01 00 00 00 00
00 00 00 02 00 00 00 00 10 00 00 01 11 22 33 44
00 00 00 01 11 22 33 44
test random_gaps random
req 40
f0 e1 d2 c3 b4 a5 96 87 10 00 00 02 00 00 00 00
00 00 00 05 01 02 03 04 10 00 00 01 00 00 00 00
10 00 00 05 00 00 00 00
exp 40
f0 e1 d2 c3 b4 a5 96 87 10 00 00 02 55 66 77 88
00 00 00 05 ca fe f0 0d 10 00 00 01 99 aa bb cc
10 00 00 05 01 02 03 04
test out_of_range random
req 32
11 22 33 44 55 66 77 88 00 00 00 10 de ad be ef
10 00 00 10 00 00 00 00 10 00 00 00 00 00 00 00
exp 32
11 22 33 44 55 66 77 88 00 00 00 10 00 00 00 00
10 00 00 10 00 00 00 00 10 00 00 00 00 00 00 00

/* sim.f */
source/gate_pkg.sv
source/local_bus_if.sv
source/short_fifo.sv
source/packet_gate.sv
source/reg_bank.sv
source/gate_top.sv
dv/gate_tb.sv

/* Bender.yml */
package:
  name: packet_gateway

sources:
  - files:
      - source/gate_pkg.sv
      - source/local_bus_if.sv
      - source/short_fifo.sv
      - source/packet_gate.sv
      - source/reg_bank.sv
      - source/gate_top.sv
  - target: test
    files:
      - dv/gate_tb.sv

/* dv/gate_tb.sv */
`timescale 1ns/1ps

module gate_tb;
	import gate_pkg::*;

	localparam time clk_period     = 100ns;
	localparam int  timeout_cycles = 2000;
	localparam int  max_bytes      = 64;
	// Longest response run ends pipe_del+10 cycles after its strobe
	localparam int  quiet_cycles   = 16;

	logic       clk;
	logic       rst_n;
	logic [7:0] rx_din;
	logic       rx_stb;
	logic       rx_end;
	logic [7:0] tx_dout;
	logic       tx_rdy;
	logic       tx_end;
	logic       tx_stb;

	integer seed;
	integer fd;
	integer rc;
	int     test_count;
	int     fail_count;
	int     err_count;
	int     total_err;
	bit     timed_out;

	// Tokens from the data file
	logic [8*32-1:0]  word;
	logic [8*32-1:0]  test_name;
	logic [8*16-1:0]  mode;
	logic [8*128-1:0] line;

	// Current test block
	logic [7:0] req_bytes [max_bytes];
	logic [7:0] exp_bytes [max_bytes];
	int         req_n;
	int         exp_n;

	gate_top dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_din  (rx_din),
		.rx_stb  (rx_stb),
		.rx_end  (rx_end),
		.tx_dout (tx_dout),
		.tx_rdy  (tx_rdy),
		.tx_end  (tx_end),
		.tx_stb  (tx_stb)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// Reads a byte count and then that many hex bytes across any number of lines
	task read_bytes(input bit to_req);
		int         n;
		logic [7:0] val;
		rc = $fscanf(fd, "%d", n);
		if (rc != 1 || n > max_bytes) begin
			$display("Malformed byte block in data file for test %0s", test_name);
			err_count++;
			n = 0;
		end
		for (int i = 0; i < n; i++) begin
			rc = $fscanf(fd, "%h", val);
			if (to_req) begin
				req_bytes[i] = val;
			end else begin
				exp_bytes[i] = val;
			end
		end
		if (to_req) begin
			req_n = n;
		end else begin
			exp_n = n;
		end
	endtask

	// One byte per cycle followed by the end pulse
	task send_request;
		for (int i = 0; i < req_n; i++) begin
			@(posedge clk);
			#1;
			rx_din = req_bytes[i];
			rx_stb = 1'b1;
		end
		@(posedge clk);
		#1;
		rx_stb = 1'b0;
		rx_din = 8'h00;
		rx_end = 1'b1;
		@(posedge clk);
		#1;
		rx_end = 1'b0;
	endtask

	// Pops and compares until all expected bytes are seen
	// A byte counts as taken when tx_stb and tx_rdy are both high
	task collect_response;
		int   got;
		int   waited;
		logic exp_end;
		got = 0;
		waited = 0;
		while (got < exp_n && !timed_out) begin
			@(posedge clk);
			#1;
			if (mode == "random") begin
				tx_stb = ($random(seed) & 32'h1) != 0;
			end else begin
				tx_stb = 1'b1;
			end
			if (tx_stb && tx_rdy) begin
				// Only the final byte of a packet with transactions is marked
				exp_end = (got == exp_n - 1) && (exp_n > nonce_bytes);
				if (tx_dout !== exp_bytes[got]) begin
					$display("FAILED %0s byte %0d tx_dout got %h expected %h",
						test_name, got, tx_dout, exp_bytes[got]);
					err_count++;
				end
				if (tx_end !== exp_end) begin
					$display("FAILED %0s byte %0d tx_end got %h expected %h",
						test_name, got, tx_end, exp_end);
					err_count++;
				end
				got++;
			end
			waited++;
			if (waited >= timeout_cycles) begin
				$display("Timeout in test %0s, only %0d of %0d response bytes arrived",
					test_name, got, exp_n);
				err_count++;
				timed_out = 1'b1;
			end
		end
		// Last accepted byte leaves on this edge
		@(posedge clk);
		#1;
		tx_stb = 1'b0;
	endtask

	task run_test;
		fork
			send_request;
			collect_response;
		join
		// Nothing may be left over once the response is complete
		repeat (quiet_cycles) @(posedge clk);
		#1;
		if (!timed_out && tx_rdy !== 1'b0) begin
			$display("FAILED %0s tx_rdy got %h expected %h after response",
				test_name, tx_rdy, 1'b0);
			err_count++;
		end
	endtask

	task report_test;
		test_count++;
		total_err += err_count;
		if (err_count == 0) begin
			$display("test %0s: ok", test_name);
		end else begin
			fail_count++;
			$display("test %0s: %0d errors", test_name, err_count);
		end
	endtask

	initial begin
		seed       = 32'hbf13;
		rst_n      = 1'b0;
		rx_din     = 8'h00;
		rx_stb     = 1'b0;
		rx_end     = 1'b0;
		tx_stb     = 1'b0;
		test_count = 0;
		fail_count = 0;
		total_err  = 0;
		timed_out  = 1'b0;
		mode       = "every";

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Outputs idle before any byte goes in
		@(posedge clk);
		#1;
		test_name = "reset_state";
		err_count = 0;
		if (tx_rdy !== 1'b0) begin
			$display("FAILED reset_state tx_rdy got %h expected %h", tx_rdy, 1'b0);
			err_count++;
		end
		if (tx_end !== 1'b0) begin
			$display("FAILED reset_state tx_end got %h expected %h", tx_end, 1'b0);
			err_count++;
		end
		report_test();

		fd = $fopen("dv/gate_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/gate_tests.txt");
			fail_count++;
		end else begin
			while (!timed_out && $fscanf(fd, "%s", word) == 1) begin
				if (word == "#") begin
					rc = $fgets(line, fd);
				end else if (word == "test") begin
					rc = $fscanf(fd, "%s %s", test_name, mode);
					err_count = 0;
				end else if (word == "req") begin
					read_bytes(1'b1);
				end else if (word == "exp") begin
					// Expected block closes a test
					read_bytes(1'b0);
					run_test();
					report_test();
				end else begin
					$display("Unknown keyword %0s in data file", word);
					fail_count++;
				end
			end
			$fclose(fd);
			if (test_count < 2) begin
				$display("No packet tests found in the data file");
				fail_count++;
			end
		end

		$display("tests run %0d, tests with errors %0d, mismatches %0d",
			test_count, fail_count, total_err);
		if (fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* source/gate_top.sv */
`timescale 1ns/1ps

module gate_top #(
	parameter int pipe_del = 3
) (
	input  logic       clk,
	input  logic       rst_n,
	// Request stream from the host
	input  logic [7:0] rx_din,
	input  logic       rx_stb,
	input  logic       rx_end,
	// Response stream pulled by the host with tx_stb
	output logic [7:0] tx_dout,
	output logic       tx_rdy,
	output logic       tx_end,
	input  logic       tx_stb
);

	// Local bus between gateway and register bank
	local_bus_if bus ();

	// Parser and bus master
	packet_gate #(
		.pipe_del (pipe_del)
	) gate (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_din  (rx_din),
		.rx_stb  (rx_stb),
		.rx_end  (rx_end),
		.tx_dout (tx_dout),
		.tx_rdy  (tx_rdy),
		.tx_end  (tx_end),
		.tx_stb  (tx_stb),
		.bus     (bus.master)
	);

	// Registers behind the bus
	reg_bank #(
		.pipe_del (pipe_del)
	) regs (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus.slave)
	);

endmodule

/* source/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank #(
	parameter int pipe_del  = 3,
	parameter int reg_count = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	local_bus_if.slave bus
);
	import gate_pkg::*;

	localparam int idx_w = (reg_count > 1) ? $clog2(reg_count) : 1;

	// Register file
	logic [data_w-1:0] regs [reg_count];

	// Read data pipeline with stage 0 first
	logic [data_w-1:0] rd_pipe [pipe_del];

	logic [idx_w-1:0]  idx;
	logic              hit;
	logic [data_w-1:0] prior;

	// Address decode
	assign idx = bus.addr[idx_w-1:0];
	assign hit = bus.addr < addr_w'(reg_count);

	// Contents before any write in this cycle
	// Addresses past the bank read as zero
	assign prior = hit ? regs[idx] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (bus.strobe && !bus.rd && hit) begin
			// Writes outside the bank are dropped
			regs[idx] <= bus.wdata;
		end
	end

	// Old value enters the pipe on every strobe
	// So a write returns what it replaced
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < pipe_del; i++) begin
				rd_pipe[i] <= '0;
			end
		end else begin
			rd_pipe[0] <= bus.strobe ? prior : '0;
			for (int i = 1; i < pipe_del; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	// Last stage lines up with pipe_del cycles after the strobe
	assign bus.rdata = rd_pipe[pipe_del-1];

	// Master must hold the bus between strobes
	a_bus_stable : assert property (@(posedge clk) disable iff (!rst_n)
		!bus.strobe |-> $stable(bus.rd) && $stable(bus.wdata) && $stable(bus.addr));

endmodule

/* source/packet_gate.sv */
`timescale 1ns/1ps

module packet_gate #(
	parameter int pipe_del = 3
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  rx_din,
	input  logic        rx_stb,
	input  logic        rx_end,
	output logic [7:0]  tx_dout,
	output logic        tx_rdy,
	output logic        tx_end,
	input  logic        tx_stb,
	local_bus_if.master bus
);
	import gate_pkg::*;

	localparam int cnt_w = $clog2(txn_bytes);

	// Receive side
	logic [cnt_w-1:0]  byte_cnt;
	logic              in_txn;
	logic              cnt_wrap;
	logic [63:0]       rx_sr;
	logic [63:0]       rx_next;
	logic              rx_loop;
	logic              txn_start;
	logic              txn_done;

	// Bus master registers
	logic              strobe_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] wdata_q;
	logic              rd_q;

	// Control word queue
	ctl_addr_t         ctl_din;
	ctl_addr_t         ctl_dout;
	logic              ctl_full;
	logic              ctl_load;

	// Response timing and shifter
	logic [pipe_del+7:0] dly;
	logic [pipe_del+8:0] dly_all;
	logic                resp_win;
	logic [63:0]         resp_sr;
	logic                resp_push;
	logic [7:0]          resp_byte;
	logic                resp_last;

	// Transmit queue
	tx_byte_t          tx_din;
	tx_byte_t          tx_head;
	logic              tx_we;
	logic              tx_re;
	logic              tx_empty;
	logic              pop_last;
	logic [5:0]        pending;

	// Incoming byte appended at the low end
	assign rx_next = {rx_sr[55:0], rx_din};

	// Counter wraps at the end of the nonce or of a transaction
	assign cnt_wrap = in_txn ? (byte_cnt == cnt_w'(txn_bytes - 1))
		: (byte_cnt == cnt_w'(nonce_bytes - 1));

	assign txn_start = rx_stb & in_txn & (byte_cnt == '0);
	assign txn_done  = rx_stb & in_txn & cnt_wrap;

	// Nonce bytes go straight back out
	assign rx_loop = rx_stb & ~in_txn;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			in_txn   <= 1'b0;
		end else if (rx_end) begin
			// End of packet restarts with a nonce
			byte_cnt <= '0;
			in_txn   <= 1'b0;
		end else if (rx_stb) begin
			byte_cnt <= cnt_wrap ? '0 : byte_cnt + 1'b1;
			if (!in_txn && cnt_wrap) begin
				in_txn <= 1'b1;
			end
		end
	end

	// Request shift register
	always_ff @(posedge clk) begin
		if (rx_stb) begin
			rx_sr <= rx_next;
		end
	end

	// Strobe follows the eighth byte by one cycle
	// Address, data and read flag then hold until the next strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strobe_q <= 1'b0;
			addr_q   <= '0;
			wdata_q  <= '0;
			rd_q     <= 1'b0;
		end else begin
			strobe_q <= txn_done;
			if (txn_done) begin
				addr_q  <= rx_next[32 +: addr_w];
				wdata_q <= rx_next[data_w-1:0];
				rd_q    <= rx_next[32 + rd_bit];
			end
		end
	end

	assign bus.strobe = strobe_q;
	assign bus.addr   = addr_q;
	assign bus.wdata  = wdata_q;
	assign bus.rd     = rd_q;

	// Shift register holds the whole transaction in the strobe cycle
	assign ctl_din = rx_sr[63:32];

	short_fifo #(
		.payload_t (ctl_addr_t),
		.aw        (2)
	) ctl_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (ctl_din),
		.we    (strobe_q),
		.re    (ctl_load),
		.dout  (ctl_dout),
		.full  (ctl_full),
		.empty ()
	);

	// Strobe delay line
	// dly_all[k] is high k cycles after the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dly <= '0;
		end else begin
			dly <= {dly[pipe_del+6:0], strobe_q};
		end
	end

	assign dly_all = {dly, strobe_q};

	// Read data is valid pipe_del cycles after the strobe
	assign ctl_load = dly_all[pipe_del];

	// Eight cycles of byte extraction after the load
	assign resp_win = |dly_all[pipe_del+8:pipe_del+1];

	// Load wins when back to back transactions overlap the last shift
	always_ff @(posedge clk) begin
		if (ctl_load) begin
			resp_sr <= {ctl_dout, bus.rdata};
		end else if (resp_win) begin
			resp_sr <= {resp_sr[55:0], 8'h00};
		end
		if (resp_win) begin
			resp_byte <= resp_sr[63:56];
		end
	end

	// Push lags the extraction window by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_push <= 1'b0;
			resp_last <= 1'b0;
		end else begin
			resp_push <= resp_win;
			resp_last <= dly_all[pipe_del+8];
		end
	end

	// Nonce loopback takes priority on the queue input
	always_comb begin
		tx_din.data = rx_loop ? rx_din : resp_byte;
		tx_din.last = ~rx_loop & resp_last;
	end

	assign tx_we = rx_loop | resp_push;
	assign tx_re = tx_stb & ~tx_empty;

	short_fifo #(
		.payload_t (tx_byte_t),
		.aw        (5)
	) tx_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (tx_din),
		.we    (tx_we),
		.re    (tx_re),
		.dout  (tx_head),
		.full  (),
		.empty (tx_empty)
	);

	// Outstanding responses let the final byte be marked
	assign pop_last = tx_re & tx_head.last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else if (txn_start && !pop_last) begin
			pending <= pending + 1'b1;
		end else if (!txn_start && pop_last) begin
			pending <= pending - 1'b1;
		end
	end

	assign tx_dout = tx_head.data;
	assign tx_rdy  = ~tx_empty;
	assign tx_end  = ~tx_empty & tx_head.last & (pending == 6'd1);

	// Control queue must have room for every issued transaction
	a_ctl_room : assert property (@(posedge clk) disable iff (!rst_n) strobe_q |-> !ctl_full);

endmodule

/* source/short_fifo.sv */
`timescale 1ns/1ps

module short_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  aw        = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t din,
	input  logic     we,
	input  logic     re,
	output payload_t dout,
	output logic     full,
	output logic     empty
);

	localparam int depth = 2 ** aw;

	// Storage
	payload_t mem [depth];

	// Pointers carry one extra wrap bit
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;

	// Write port
	always_ff @(posedge clk) begin
		if (we && !full) begin
			mem[wr_ptr[aw-1:0]] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (we && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (re && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Head entry shows without a read
	assign dout = mem[rd_ptr[aw-1:0]];

	// Equal slots with differing wrap bits mean full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

	// Overflow loses data for good
	a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) we |-> !full);

	// Underflow would repeat a stale entry
	a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) re |-> !empty);

endmodule

/* source/local_bus_if.sv */
`timescale 1ns/1ps

interface local_bus_if;
	import gate_pkg::*;

	// Register address
	logic [addr_w-1:0] addr;

	// Write data toward the slave
	logic [data_w-1:0] wdata;

	// Read data back from the slave
	// Valid a fixed number of cycles after the strobe
	logic [data_w-1:0] rdata;

	// One cycle pulse per transaction
	logic              strobe;

	// High for a read, low for a write
	logic              rd;

	// Gateway side
	modport master (output addr, wdata, strobe, rd, input rdata);

	// Register bank side
	modport slave (input addr, wdata, strobe, rd, output rdata);

endinterface

/* source/gate_pkg.sv */
package gate_pkg;

	// Local bus address width
	localparam int addr_w = 24;

	// Local bus data width
	localparam int data_w = 32;

	// Bytes in the leading nonce
	localparam int nonce_bytes = 8;

	// Bytes in one request transaction
	// Each response is the same length
	localparam int txn_bytes = 8;

	// Read flag position inside the control word
	localparam int rd_bit = 28;

	// Control and address word as received
	// Bits 23 to 0 hold the address
	// Kept in the control FIFO until the read data comes back
	typedef logic [31:0] ctl_addr_t;

	// One entry of the transmit queue
	typedef struct packed {
		// Byte shown to the host
		logic [7:0] data;
		// Set on the eighth byte of a response
		logic       last;
	} tx_byte_t;

endpackage
